// ==== hdl/isa_pkg.sv ====
/*
 * ISA definitions for the fetch stage
 * next-pc and vector selectors, interrupt cause width, fixed addresses
 */

package isa_pkg;

  ////////////////////////////////////////
  // selectors
  ////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,  // boot base + offset
    PC_JUMP = 3'd1,  // jump/branch target from ex
    PC_EXC  = 3'd2,  // exception, irq or debug vector
    PC_ERET = 3'd3   // return from trap, mepc
  } pc_sel_e;

  // kind of vector when pc_sel_e is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC = 2'd0,  // synchronous exception -> mtvec base
    EXC_PC_IRQ = 2'd1,  // vectored interrupt -> base + 4*cause
    EXC_PC_DBG = 2'd2   // debug halt request
  } exc_sel_e;

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  localparam int unsigned ExcCauseW = 5;  // irq cause bits

  localparam logic [31:0] DmHaltAddr = 32'h1A11_0800;  // debug module halt entry

  // boot base is 256 byte aligned, first fetch sits 0x80 above it
  localparam logic [7:0] BootOffset = 8'h80;

endpackage

// ==== hdl/fetch_pkg.sv ====
/*
 * Fetch buffer definitions
 * slot count, derived index and credit widths, slot state encoding
 */

package fetch_pkg;

  localparam int unsigned NumSlots = 4;  // power of two, 2 and 8 also fine

  localparam int unsigned SlotIdxW = $clog2(NumSlots);  // ring pointer width

  // one extra bit so the counter can hold NumSlots
  localparam int unsigned CreditW = SlotIdxW + 1;

  // life cycle of one buffer entry
  typedef enum logic [1:0] {
    SLOT_FREE    = 2'd0,  // owns a credit, nothing in flight
    SLOT_PENDING = 2'd1,  // granted on the bus, waiting for rvalid
    SLOT_STALE   = 2'd2,  // squashed while pending, response still owed
    SLOT_FULL    = 2'd3   // holds a word for decode
  } slot_state_e;

endpackage

// ==== hdl/slot_if.sv ====
/*
 * Per-slot bundle between the request issuer, one fetch slot and the drain
 * issuer allocates and fills, drain takes, slot reports state and release
 */
`timescale 1ns/1ps

interface slot_if;

  logic        alloc;       // bus grant claims this slot
  logic [31:0] alloc_addr;  // address of the granted request
  logic        fill;        // response for this slot
  logic [31:0] fill_data;
  logic        fill_err;
  logic        flush;       // registered pc_set, same on every slot
  logic        take;        // drain copies the word out

  fetch_pkg::slot_state_e state;
  logic [31:0]            addr;
  logic [31:0]            data;
  logic                   err;
  logic                   rel;  // slot went back to free, credit returns

  modport issuer (output alloc, alloc_addr, fill, fill_data, fill_err, flush,
                  input  rel);

  modport slot   (input  alloc, alloc_addr, fill, fill_data, fill_err, flush, take,
                  output state, addr, data, err, rel);

  modport drain  (output take,
                  input  state, addr, data, err, rel, flush);

endinterface

// ==== hdl/fetch_issue.sv ====
/*
 * Fetch request issuer
 * picks the next pc, issues word requests against slot credits and
 * steers bus responses into the slot ring in grant order
 */
`timescale 1ns/1ps

module fetch_issue (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,             // core wants instructions
  input  logic                            pc_set_i,          // redirect
  input  isa_pkg::pc_sel_e                pc_mux_i,
  input  isa_pkg::exc_sel_e               exc_mux_i,
  input  logic [isa_pkg::ExcCauseW-1:0]   exc_cause_i,
  input  logic [31:0]                     boot_addr_i,
  input  logic [31:0]                     branch_target_i,
  input  logic [31:0]                     csr_mepc_i,
  input  logic [31:0]                     csr_mtvec_i,
  output logic                            instr_req_o,
  output logic [31:0]                     instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [31:0]                     instr_rdata_i,
  input  logic                            instr_err_i,
  output logic                            csr_mtvec_init_o,  // boot redirect, init mtvec
  output logic                            busy_o,
  output logic [fetch_pkg::SlotIdxW-1:0]  fill_ptr_o,        // fill pointer after this cycle
  slot_if.issuer                          slots [fetch_pkg::NumSlots]
);

  logic [31:0] exc_pc;
  logic [31:0] fetch_addr_n;
  logic [31:0] addr_q;        // address on the bus
  logic        fetch_en_q;    // set by the first redirect
  logic        flush_q;
  logic        grant;

  logic [fetch_pkg::CreditW-1:0]  credit_q;
  logic [fetch_pkg::CreditW-1:0]  rel_cnt;
  logic [fetch_pkg::CreditW-1:0]  outst_q;   // granted, not yet answered
  logic [fetch_pkg::SlotIdxW-1:0] alloc_q;
  logic [fetch_pkg::SlotIdxW-1:0] fill_q;
  logic [fetch_pkg::NumSlots-1:0] rel;

  ////////////////////////////////////////
  // next address
  ////////////////////////////////////////

  always_comb begin
    unique case (exc_mux_i)
      isa_pkg::EXC_PC_EXC: exc_pc = {csr_mtvec_i[31:8], 8'h00};
      // base + 4*cause, cause fits below bit 7
      isa_pkg::EXC_PC_IRQ: exc_pc = {csr_mtvec_i[31:8], 1'b0, exc_cause_i, 2'b00};
      isa_pkg::EXC_PC_DBG: exc_pc = isa_pkg::DmHaltAddr;
      default:             exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      isa_pkg::PC_BOOT: fetch_addr_n = {boot_addr_i[31:8], isa_pkg::BootOffset};
      isa_pkg::PC_JUMP: fetch_addr_n = branch_target_i;
      isa_pkg::PC_EXC:  fetch_addr_n = exc_pc;
      isa_pkg::PC_ERET: fetch_addr_n = csr_mepc_i;   // back to trapped pc
      default:          fetch_addr_n = {boot_addr_i[31:8], isa_pkg::BootOffset};
    endcase
  end

  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == isa_pkg::PC_BOOT);

  ////////////////////////////////////////
  // bus request
  ////////////////////////////////////////

  // only ask while a free slot is guaranteed for the answer
  assign instr_req_o  = req_i & fetch_en_q & (credit_q != '0);
  assign instr_addr_o = addr_q;
  assign grant        = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      fetch_en_q <= 1'b0;
      flush_q    <= 1'b0;
    end else begin
      flush_q <= pc_set_i;  // squash one cycle later, old grants land first
      if (pc_set_i) begin
        addr_q     <= {fetch_addr_n[31:2], 2'b00};  // word fetches only
        fetch_en_q <= 1'b1;
      end else if (grant) begin
        addr_q <= addr_q + 32'd4;
      end
    end
  end

  ////////////////////////////////////////
  // credits and ring pointers
  ////////////////////////////////////////

  // several slots can free at once on a flush
  always_comb begin
    rel_cnt = '0;
    for (int i = 0; i < fetch_pkg::NumSlots; i++) begin
      rel_cnt = rel_cnt + fetch_pkg::CreditW'(rel[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= fetch_pkg::CreditW'(fetch_pkg::NumSlots);
      outst_q  <= '0;
      alloc_q  <= '0;
      fill_q   <= '0;
    end else begin
      credit_q <= credit_q - fetch_pkg::CreditW'(grant) + rel_cnt;
      outst_q  <= outst_q + fetch_pkg::CreditW'(grant) - fetch_pkg::CreditW'(instr_rvalid_i);
      alloc_q  <= alloc_q + fetch_pkg::SlotIdxW'(grant);
      fill_q   <= fill_q + fetch_pkg::SlotIdxW'(instr_rvalid_i);
    end
  end

  assign busy_o     = (outst_q != '0);
  assign fill_ptr_o = fill_q + fetch_pkg::SlotIdxW'(instr_rvalid_i);

  // per-slot strobes, responses come back in grant order
  for (genvar g = 0; g < fetch_pkg::NumSlots; g++) begin : gen_slot_ctl
    assign slots[g].alloc      = grant & (alloc_q == fetch_pkg::SlotIdxW'(g));
    assign slots[g].alloc_addr = addr_q;
    assign slots[g].fill       = instr_rvalid_i & (fill_q == fetch_pkg::SlotIdxW'(g));
    assign slots[g].fill_data  = instr_rdata_i;
    assign slots[g].fill_err   = instr_err_i;
    assign slots[g].flush      = flush_q;
    assign rel[g]              = slots[g].rel;
  end

endmodule

// ==== hdl/fetch_slot.sv ====
/*
 * One fetch buffer entry
 * tracks its request from grant to hand-off and returns its credit
 */
`timescale 1ns/1ps

module fetch_slot (
  input  logic   clk_i,
  input  logic   rst_ni,
  slot_if.slot   s
);

  fetch_pkg::slot_state_e state_q, state_d;
  logic [31:0]            addr_q;
  logic [31:0]            data_q;
  logic                   err_q;
  logic                   rel;

  always_comb begin
    state_d = state_q;
    rel     = 1'b0;
    unique case (state_q)
      fetch_pkg::SLOT_FREE: begin
        if (s.alloc) state_d = fetch_pkg::SLOT_PENDING;
      end
      fetch_pkg::SLOT_PENDING: begin
        if (s.flush && s.fill) begin
          state_d = fetch_pkg::SLOT_FREE;  // old word arrives during squash, drop it
          rel     = 1'b1;
        end else if (s.flush) begin
          state_d = fetch_pkg::SLOT_STALE;  // still owed a response
        end else if (s.fill) begin
          state_d = fetch_pkg::SLOT_FULL;
        end
      end
      fetch_pkg::SLOT_STALE: begin
        if (s.fill) begin
          state_d = fetch_pkg::SLOT_FREE;
          rel     = 1'b1;
        end
      end
      fetch_pkg::SLOT_FULL: begin
        // either handed to decode or squashed
        if (s.take || s.flush) begin
          state_d = fetch_pkg::SLOT_FREE;
          rel     = 1'b1;
        end
      end
      default: state_d = fetch_pkg::SLOT_FREE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= fetch_pkg::SLOT_FREE;
    else         state_q <= state_d;
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (s.alloc && state_q == fetch_pkg::SLOT_FREE) addr_q <= s.alloc_addr;
    if (s.fill && !s.flush && state_q == fetch_pkg::SLOT_PENDING) begin
      data_q <= s.fill_data;
      err_q  <= s.fill_err;
    end
  end

  assign s.state = state_q;
  assign s.addr  = addr_q;
  assign s.data  = data_q;
  assign s.err   = err_q;
  assign s.rel   = rel;

endmodule

// ==== hdl/fetch_drain.sv ====
/*
 * In-order drain of the slot ring
 * walks the ring oldest first, skips squashed entries and feeds the IF-ID register
 */
`timescale 1ns/1ps

module fetch_drain (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            pc_set_i,
  input  logic [fetch_pkg::SlotIdxW-1:0]  fill_ptr_i,   // first slot of the new stream
  input  logic                            id_ready_i,
  output logic                            instr_valid_o,
  output logic [31:0]                     instr_rdata_o,
  output logic [31:0]                     instr_pc_o,
  output logic                            instr_err_o,
  slot_if.drain                           slots [fetch_pkg::NumSlots]
);

  fetch_pkg::slot_state_e         st     [fetch_pkg::NumSlots];
  logic [31:0]                    addr_v [fetch_pkg::NumSlots];
  logic [31:0]                    data_v [fetch_pkg::NumSlots];
  logic [fetch_pkg::NumSlots-1:0] err_v;
  logic [fetch_pkg::NumSlots-1:0] rel_v;
  logic [fetch_pkg::NumSlots-1:0] flush_v;

  logic [fetch_pkg::SlotIdxW-1:0] rd_q;   // oldest live slot
  logic                           flush;
  logic                           take;
  logic                           skip;
  logic                           valid_q;

  for (genvar g = 0; g < fetch_pkg::NumSlots; g++) begin : gen_slot_rd
    assign st[g]      = slots[g].state;
    assign addr_v[g]  = slots[g].addr;
    assign data_v[g]  = slots[g].data;
    assign err_v[g]   = slots[g].err;
    assign rel_v[g]   = slots[g].rel;
    assign flush_v[g] = slots[g].flush;
    assign slots[g].take = take & (rd_q == fetch_pkg::SlotIdxW'(g));
  end

  assign flush = |flush_v;  // same pulse on every slot

  // nothing moves out while a redirect is in progress
  assign take = (st[rd_q] == fetch_pkg::SLOT_FULL) & (~valid_q | id_ready_i) &
                ~pc_set_i & ~flush;
  // squashed slot answered, move on
  assign skip = (st[rd_q] == fetch_pkg::SLOT_STALE) & rel_v[rd_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= '0;
    end else if (flush) begin
      rd_q <= fill_ptr_i;  // everything before this was freed or goes stale
    end else if (take || skip) begin
      rd_q <= rd_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // IF-ID register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (pc_set_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;  // consumed, nothing behind it yet
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      instr_rdata_o <= data_v[rd_q];
      instr_pc_o    <= addr_v[rd_q];
      instr_err_o   <= err_v[rd_q];
    end
  end

  assign instr_valid_o = valid_q;

endmodule

// ==== hdl/if_stage_top.sv ====
/*
 * Instruction fetch stage top
 * issuer, ring of fetch slots and in-order drain toward decode
 */
`timescale 1ns/1ps

module if_stage_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          pc_set_i,
  input  isa_pkg::pc_sel_e              pc_mux_i,
  input  isa_pkg::exc_sel_e             exc_mux_i,
  input  logic [isa_pkg::ExcCauseW-1:0] exc_cause_i,
  input  logic [31:0]                   boot_addr_i,
  input  logic [31:0]                   branch_target_i,
  input  logic [31:0]                   csr_mepc_i,
  input  logic [31:0]                   csr_mtvec_i,
  output logic                          csr_mtvec_init_o,
  // instruction bus
  output logic                          instr_req_o,
  output logic [31:0]                   instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [31:0]                   instr_rdata_i,
  input  logic                          instr_err_i,
  // toward decode
  input  logic                          id_ready_i,
  output logic                          instr_valid_o,
  output logic [31:0]                   instr_rdata_o,
  output logic [31:0]                   instr_pc_o,
  output logic                          instr_err_o,
  output logic                          busy_o
);

  logic [fetch_pkg::SlotIdxW-1:0] fill_ptr;

  slot_if slot_bus [fetch_pkg::NumSlots] ();

  fetch_issue i_issue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_mux_i        (exc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .busy_o           (busy_o),
    .fill_ptr_o       (fill_ptr),
    .slots            (slot_bus)
  );

  for (genvar g = 0; g < fetch_pkg::NumSlots; g++) begin : gen_slot
    fetch_slot i_slot (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .s      (slot_bus[g])
    );
  end

  fetch_drain i_drain (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pc_set_i      (pc_set_i),
    .fill_ptr_i    (fill_ptr),
    .id_ready_i    (id_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_pc_o    (instr_pc_o),
    .instr_err_o   (instr_err_o),
    .slots         (slot_bus)
  );

endmodule

// ==== bench/if_stage_properties.sv ====
/*
 * Bound checks on the fetch stage
 * instruction bus handshake, response accounting, credits, decode stall
 */
`timescale 1ns/1ps

module if_stage_properties (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          pc_set_i,
  input logic                          instr_req_i,
  input logic [31:0]                   instr_addr_i,
  input logic                          instr_gnt_i,
  input logic                          instr_rvalid_i,
  input logic                          busy_i,         // some grant still unanswered
  input logic                          id_ready_i,
  input logic                          instr_valid_i,
  input logic [31:0]                   instr_pc_i,
  input logic [31:0]                   instr_rdata_i,
  input logic [fetch_pkg::CreditW-1:0] credit_i       // issuer credit counter
);

  ////////////////////////////////////////
  // instruction bus
  ////////////////////////////////////////

  // request and address hold until granted, only a redirect may move them
  bus_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i && !pc_set_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or moved before its grant");

  rvalid_owed_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> busy_i)  // response needs an earlier grant
    else $error("response seen with no unanswered grant");

  ////////////////////////////////////////
  // slots and decode side
  ////////////////////////////////////////

  credit_max_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_i <= fetch_pkg::CreditW'(fetch_pkg::NumSlots))
    else $error("credit counter above the number of slots");

  // word waits in the IF-ID register while decode stalls
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && !id_ready_i && !pc_set_i |=>
      instr_valid_i && $stable(instr_pc_i) && $stable(instr_rdata_i))
    else $error("decode output changed while stalled");

endmodule

// ==== bench/if_stage_tb.sv ====
/*
 * Fetch stage testbench
 * table driven redirects, pipelined memory with random latency,
 * in-order stream checks toward decode
 */
`timescale 1ns/1ps

module if_stage_tb;

  localparam logic [31:0] boot_addr_val = 32'h0000_8044;  // low byte dropped by the stage
  localparam logic [31:0] mtvec_val     = 32'h0000_1001;  // base 0x1000 with the mode bit set
  localparam logic [31:0] data_key      = 32'h5a5a_0000;  // memory word = addr ^ key
  localparam logic [31:0] err_lo        = 32'h0000_3000;  // bus error window
  localparam logic [31:0] err_hi        = 32'h0000_301f;
  localparam logic [31:0] idle_target   = 32'h0000_7700;  // on the target input a row leaves unused
  localparam int          num_rows      = 9;
  localparam int          wait_limit    = 4000;           // cycles per wait

  // one redirect and what to collect after it
  typedef struct packed {
    isa_pkg::pc_sel_e  pc_mux;
    isa_pkg::exc_sel_e exc_mux;
    logic [4:0]        cause;
    logic [31:0]       target;   // jump target or mepc
    int unsigned       count;    // instructions to collect
    logic              bp;       // random id_ready gaps
  } row_t;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_i;
  logic                          pc_set_i;
  isa_pkg::pc_sel_e              pc_mux_i;
  isa_pkg::exc_sel_e             exc_mux_i;
  logic [isa_pkg::ExcCauseW-1:0] exc_cause_i;
  logic [31:0]                   boot_addr_i;
  logic [31:0]                   branch_target_i;
  logic [31:0]                   csr_mepc_i;
  logic [31:0]                   csr_mtvec_i;
  logic                          csr_mtvec_init_o;
  logic                          instr_req_o;
  logic [31:0]                   instr_addr_o;
  logic                          instr_gnt_i;
  logic                          instr_rvalid_i;
  logic [31:0]                   instr_rdata_i;
  logic                          instr_err_i;
  logic                          id_ready_i;
  logic                          instr_valid_o;
  logic [31:0]                   instr_rdata_o;
  logic [31:0]                   instr_pc_o;
  logic                          instr_err_o;
  logic                          busy_o;

  row_t        rows [num_rows];
  logic [31:0] pend [$];      // granted addresses in grant order
  logic [31:0] got_pc [$];    // words accepted by decode
  logic [31:0] got_data [$];
  logic        got_err [$];
  logic        collecting;
  logic        bp_on;
  int          mtvec_pulses;
  int          errors;
  int          checks;

  if_stage_top i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_mux_i        (exc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .id_ready_i       (id_ready_i),
    .instr_valid_o    (instr_valid_o),
    .instr_rdata_o    (instr_rdata_o),
    .instr_pc_o       (instr_pc_o),
    .instr_err_o      (instr_err_o),
    .busy_o           (busy_o)
  );

  bind if_stage_top if_stage_properties i_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pc_set_i       (pc_set_i),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_i         (busy_o),
    .id_ready_i     (id_ready_i),
    .instr_valid_i  (instr_valid_o),
    .instr_pc_i     (instr_pc_o),
    .instr_rdata_i  (instr_rdata_o),
    .credit_i       (i_issue.credit_q)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // memory model and decode side
  ////////////////////////////////////////

  function automatic logic in_err_window(input logic [31:0] a);
    in_err_window = (a >= err_lo) && (a <= err_hi);
  endfunction

  // sample at the falling edge and drive 2 ns after the rising edge
  initial begin
    logic [31:0] head;
    void'($urandom(32'hc592_bd34));
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    id_ready_i     = 1'b0;
    mtvec_pulses   = 0;
    forever begin
      @(negedge clk_i);
      checks++;
      if (busy_o !== (pend.size() != 0)) begin  // grants still owed a response
        $display("Fail busy_o got %h exp %h", busy_o, pend.size() != 0);
        errors++;
      end
      if (instr_rvalid_i) void'(pend.pop_front());  // answered at the coming edge
      if (instr_req_o && instr_gnt_i) pend.push_back(instr_addr_o);
      if (csr_mtvec_init_o) mtvec_pulses++;
      if (collecting && instr_valid_o && id_ready_i) begin
        got_pc.push_back(instr_pc_o);
        got_data.push_back(instr_rdata_o);
        got_err.push_back(instr_err_o);
      end
      @(posedge clk_i);
      #2;
      instr_gnt_i    = ($urandom % 4) != 0;
      instr_rvalid_i = (pend.size() != 0) && (($urandom % 3) != 0);  // in grant order
      head           = (pend.size() != 0) ? pend[0] : '0;
      instr_rdata_i  = head ^ data_key;
      instr_err_i    = instr_rvalid_i && in_err_window(head);
      id_ready_i     = bp_on ? (($urandom % 2) != 0) : 1'b1;
    end
  end

  ////////////////////////////////////////
  // expected stream
  ////////////////////////////////////////

  function automatic logic [31:0] start_pc(input row_t r);
    logic [31:0] vec_base;
    vec_base = mtvec_val & 32'hffff_ff00;
    case (r.pc_mux)
      isa_pkg::PC_BOOT: start_pc = (boot_addr_val & 32'hffff_ff00) + 32'h80;
      isa_pkg::PC_JUMP: start_pc = r.target & 32'hffff_fffc;
      isa_pkg::PC_ERET: start_pc = r.target & 32'hffff_fffc;
      default: begin
        if (r.exc_mux == isa_pkg::EXC_PC_IRQ) start_pc = vec_base + 32'(r.cause) * 4;
        else if (r.exc_mux == isa_pkg::EXC_PC_DBG) start_pc = isa_pkg::DmHaltAddr;
        else start_pc = vec_base;
      end
    endcase
  endfunction

  task automatic load_rows();
    rows[0] = '{isa_pkg::PC_BOOT, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0, 12, 1'b0};
    rows[1] = '{isa_pkg::PC_JUMP, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0000_4000, 10, 1'b0};
    rows[2] = '{isa_pkg::PC_EXC,  isa_pkg::EXC_PC_EXC, 5'd0, 32'h0, 6, 1'b0};
    rows[3] = '{isa_pkg::PC_EXC,  isa_pkg::EXC_PC_IRQ, 5'd7, 32'h0, 6, 1'b0};
    rows[4] = '{isa_pkg::PC_EXC,  isa_pkg::EXC_PC_DBG, 5'd0, 32'h0, 6, 1'b0};
    rows[5] = '{isa_pkg::PC_ERET, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0000_5124, 6, 1'b0};
    rows[6] = '{isa_pkg::PC_JUMP, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0000_6000, 40, 1'b1};
    rows[7] = '{isa_pkg::PC_JUMP, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0000_2ff8, 10, 1'b1};
    rows[8] = '{isa_pkg::PC_BOOT, isa_pkg::EXC_PC_EXC, 5'd0, 32'h0, 4, 1'b1};
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] start;
    logic [31:0] exp_pc;
    int          base;
    int          n;
    int          wait_cnt;
    int          row_err;
    int          mt_base;
    int          mt_exp;
    logic        timed_out;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = isa_pkg::PC_BOOT;
    exc_mux_i       = isa_pkg::EXC_PC_EXC;
    exc_cause_i     = '0;
    boot_addr_i     = boot_addr_val;
    branch_target_i = '0;
    csr_mepc_i      = '0;
    csr_mtvec_i     = mtvec_val;
    collecting      = 1'b0;
    bp_on           = 1'b0;
    errors          = 0;
    checks          = 0;
    timed_out       = 1'b0;
    load_rows();
    repeat (3) @(posedge clk_i);  // reset for 3 cycles
    #2;
    rst_ni = 1'b1;
    req_i  = 1'b1;                // still idle until the first redirect
    repeat (2) @(negedge clk_i);
    checks += 3;
    if (instr_req_o !== 1'b0) begin
      $display("Fail instr_req_o got %h exp %h", instr_req_o, 1'b0);
      errors++;
    end
    if (instr_valid_o !== 1'b0) begin
      $display("Fail instr_valid_o got %h exp %h", instr_valid_o, 1'b0);
      errors++;
    end
    if (csr_mtvec_init_o !== 1'b0) begin
      $display("Fail csr_mtvec_init_o got %h exp %h", csr_mtvec_init_o, 1'b0);
      errors++;
    end
    $display("test idle: outputs low before the first redirect, %0d errors", errors);
    @(posedge clk_i);
    #2;
    for (int t = 0; t < num_rows && !timed_out; t++) begin
      row_err         = errors;
      start           = start_pc(rows[t]);
      collecting      = 1'b0;          // words taken during the redirect are old
      mt_base         = mtvec_pulses;
      bp_on           = rows[t].bp;
      pc_mux_i        = rows[t].pc_mux;
      exc_mux_i       = rows[t].exc_mux;
      exc_cause_i     = rows[t].cause;
      // target only on the input the row selects
      branch_target_i = (rows[t].pc_mux == isa_pkg::PC_JUMP) ? rows[t].target : idle_target;
      csr_mepc_i      = (rows[t].pc_mux == isa_pkg::PC_ERET) ? rows[t].target : idle_target;
      pc_set_i        = 1'b1;
      @(posedge clk_i);
      #2;
      pc_set_i   = 1'b0;
      base       = got_pc.size();
      collecting = 1'b1;
      wait_cnt   = 0;
      while (got_pc.size() < base + int'(rows[t].count) && wait_cnt < wait_limit) begin
        @(posedge clk_i);
        wait_cnt++;
      end
      #2;
      if (got_pc.size() < base + int'(rows[t].count)) begin
        timed_out = 1'b1;
        $display("test %0d timed out: %0d of %0d instructions reached decode",
                 t, got_pc.size() - base, rows[t].count);
      end else begin
        n = got_pc.size() - base;  // extras past count must continue the stream
        for (int k = 0; k < n; k++) begin
          exp_pc = start + 32'(4 * k);
          checks += 3;
          if (got_pc[base+k] !== exp_pc) begin
            $display("Fail test %0d item %0d instr_pc_o got %h exp %h",
                     t, k, got_pc[base+k], exp_pc);
            errors++;
          end
          if (got_data[base+k] !== (exp_pc ^ data_key)) begin
            $display("Fail test %0d item %0d instr_rdata_o got %h exp %h",
                     t, k, got_data[base+k], exp_pc ^ data_key);
            errors++;
          end
          if (got_err[base+k] !== in_err_window(exp_pc)) begin
            $display("Fail test %0d item %0d instr_err_o got %h exp %h",
                     t, k, got_err[base+k], in_err_window(exp_pc));
            errors++;
          end
        end
        mt_exp = (rows[t].pc_mux == isa_pkg::PC_BOOT) ? 1 : 0;  // boot redirect only
        checks++;
        if (mtvec_pulses - mt_base != mt_exp) begin
          $display("Fail test %0d csr_mtvec_init_o pulses got %h exp %h",
                   t, mtvec_pulses - mt_base, mt_exp);
          errors++;
        end
        $display("test %0d %s from %h: %0d instructions, %0d errors",
                 t, rows[t].pc_mux.name(), start, n, errors - row_err);
      end
    end
    $display("tests %0d, checks %0d, errors %0d, timeout %0d",
             num_rows + 1, checks, errors, timed_out);
    if (timed_out || errors != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

// ==== if_stage_top.f ====
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/slot_if.sv
hdl/fetch_issue.sv
hdl/fetch_slot.sv
hdl/fetch_drain.sv
hdl/if_stage_top.sv
bench/if_stage_properties.sv
bench/if_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch stage testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module if_stage_tb \
  -f if_stage_top.f -o if_stage_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/if_stage_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation done"
